/* hdl/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd11;

    // one instruction word, read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] shamt;
            logic [5:0]        funct;
        } r;
        struct packed {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm16;
        } i;
    } instr_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [mips_pkg::XLEN-1:0]     a,
    input  logic [mips_pkg::XLEN-1:0]     b,
    input  logic [mips_pkg::REG_AW-1:0]   shamt,
    input  logic [mips_pkg::ALU_OP_W-1:0] op,
    output logic [mips_pkg::XLEN-1:0]     result
);
    import mips_pkg::*;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            lt_signed;

    assign sum  = a + b;
    assign diff = a - b;

    // signs differ, so the negative one is smaller
    assign lt_signed = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : diff[XLEN-1];

    always_comb begin
        case (op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            // shifts act on rt
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = $signed(b) >>> shamt;
            // upper half already placed by decode
            ALU_LUI:  result = b;
            default:  result = sum;
        endcase
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic [mips_pkg::REG_AW-1:0] rs,
    input  logic [mips_pkg::REG_AW-1:0] rt,
    input  logic [mips_pkg::REG_AW-1:0] wreg,
    input  logic                        wen,
    input  logic [mips_pkg::XLEN-1:0]   wdata,
    output logic [mips_pkg::XLEN-1:0]   rs_data,
    output logic [mips_pkg::XLEN-1:0]   rt_data
);
    import mips_pkg::*;

    // $0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            wr_hit;

    assign wr_hit = wen && wreg != '0;

    always_ff @(posedge aclk) begin
        if (aresetn && wr_hit) begin
            regs[wreg] <= wdata;
        end
    end

    // same-cycle write shows on the read ports
    assign rs_data = (rs == '0)             ? '0    :
                     (wr_hit && wreg == rs) ? wdata : regs[rs];
    assign rt_data = (rt == '0)             ? '0    :
                     (wr_hit && wreg == rt) ? wdata : regs[rt];

endmodule

/* hdl/pipe_control.sv */
`timescale 1ns/1ns

module pipe_control (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic [mips_pkg::REG_AW-1:0] id_rs,
    input  logic [mips_pkg::REG_AW-1:0] id_rt,
    input  logic                        id_uses_rs,
    input  logic                        id_uses_rt,
    input  logic                        ex_regwen,
    input  logic [mips_pkg::REG_AW-1:0] ex_wreg,
    output logic                        stall,
    output logic                        ex_bubble
);

    logic hazard;
    logic stalled_q;

    // branch operand still being computed in execute
    assign hazard = ex_regwen &&
                    ((id_uses_rs && id_rs == ex_wreg) || (id_uses_rt && id_rt == ex_wreg));

    // one stall per branch, the retry takes the value from writeback
    assign stall     = hazard && !stalled_q;
    assign ex_bubble = stall;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stalled_q <= 1'b0;
        end else begin
            stalled_q <= stall;
        end
    end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      stall,
    input  logic                      branch_taken,
    input  logic [mips_pkg::XLEN-1:0] branch_target,
    output logic                      inst_req,
    output logic [mips_pkg::XLEN-1:0] inst_addr,
    output logic [mips_pkg::XLEN-1:0] id_pc
);
    import mips_pkg::*;

    logic [XLEN-1:0] pc;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            inst_req <= 1'b0;
        end else begin
            inst_req <= 1'b1;
        end
    end

    // on a stall fetch the word in decode again
    assign inst_addr = stall ? id_pc : pc;

    // pc already points at the delay slot when a branch resolves
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc <= RESET_PC;
        end else if (inst_req && !stall) begin
            pc <= branch_taken ? branch_target : pc + 4;
        end
    end

    // address issued last cycle, pairs with inst_rdata
    always_ff @(posedge aclk) begin
        id_pc <= inst_addr;
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic [mips_pkg::XLEN-1:0]     inst_rdata,
    input  logic [mips_pkg::XLEN-1:0]     id_pc,
    input  logic [mips_pkg::XLEN-1:0]     rs_data,
    input  logic [mips_pkg::XLEN-1:0]     rt_data,
    input  logic                          stall,
    input  logic                          ex_bubble,
    input  logic                          wb_regwen,
    input  logic [mips_pkg::REG_AW-1:0]   wb_wreg,
    input  logic [mips_pkg::XLEN-1:0]     wb_data,
    output logic [mips_pkg::REG_AW-1:0]   id_rs,
    output logic [mips_pkg::REG_AW-1:0]   id_rt,
    output logic                          id_uses_rs,
    output logic                          id_uses_rt,
    output logic                          branch_taken,
    output logic [mips_pkg::XLEN-1:0]     branch_target,
    output logic [mips_pkg::XLEN-1:0]     ex_pc,
    output logic [mips_pkg::XLEN-1:0]     ex_a,
    output logic [mips_pkg::XLEN-1:0]     ex_b,
    output logic [mips_pkg::XLEN-1:0]     ex_imm,
    output logic                          ex_use_imm,
    output logic                          ex_load,
    output logic                          ex_store,
    output logic                          ex_regwen,
    output logic [mips_pkg::REG_AW-1:0]   ex_wreg,
    output logic [mips_pkg::REG_AW-1:0]   ex_rs,
    output logic [mips_pkg::REG_AW-1:0]   ex_rt,
    output logic [mips_pkg::REG_AW-1:0]   ex_shamt,
    output logic [mips_pkg::ALU_OP_W-1:0] ex_alu_op
);
    import mips_pkg::*;

    logic                fetch_live;
    logic                id_valid;
    instr_t              ins;
    logic                op_special;
    logic                op_branch;
    logic                op_load;
    logic                op_store;
    logic                op_imm;
    logic                fn_known;
    logic                writes;
    logic [REG_AW-1:0]   wreg;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     rs_fwd;
    logic [XLEN-1:0]     rt_fwd;
    logic                rs_eq;

    // first response after reset answers no request
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fetch_live <= 1'b0;
            id_valid   <= 1'b0;
        end else begin
            fetch_live <= 1'b1;
            id_valid   <= fetch_live;
        end
    end

    assign ins   = id_valid ? inst_rdata : '0;
    assign id_rs = ins.r.rs;
    assign id_rt = ins.r.rt;

    assign op_special = ins.r.opcode == OPC_SPECIAL;
    assign op_branch  = ins.i.opcode == OPC_BEQ || ins.i.opcode == OPC_BNE;
    assign op_load    = ins.i.opcode == OPC_LW;
    assign op_store   = ins.i.opcode == OPC_SW;

    always_comb begin
        alu_op   = ALU_ADD;
        op_imm   = 1'b0;
        fn_known = 1'b1;
        if (op_special) begin
            case (ins.r.funct)
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                FN_SLL:  alu_op = ALU_SLL;
                FN_SRL:  alu_op = ALU_SRL;
                FN_SRA:  alu_op = ALU_SRA;
                default: fn_known = 1'b0;
            endcase
        end else begin
            op_imm = 1'b1;
            case (ins.i.opcode)
                OPC_ADDIU: alu_op = ALU_ADD;
                OPC_ANDI:  alu_op = ALU_AND;
                OPC_ORI:   alu_op = ALU_OR;
                OPC_XORI:  alu_op = ALU_XOR;
                OPC_SLTI:  alu_op = ALU_SLT;
                OPC_LUI:   alu_op = ALU_LUI;
                default:   op_imm = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (ins.i.opcode)
            OPC_ANDI, OPC_ORI, OPC_XORI: imm = {{(XLEN-16){1'b0}}, ins.i.imm16};
            OPC_LUI: imm = {ins.i.imm16, {(XLEN-16){1'b0}}};
            default: imm = {{(XLEN-16){ins.i.imm16[15]}}, ins.i.imm16};
        endcase
    end

    assign writes = (op_special && fn_known) || op_imm || op_load;
    assign wreg   = op_special ? ins.r.rd : ins.i.rt;

    assign rs_fwd = (wb_regwen && wb_wreg == id_rs) ? wb_data : rs_data;
    assign rt_fwd = (wb_regwen && wb_wreg == id_rt) ? wb_data : rt_data;

    // beq/bne read both registers
    assign id_uses_rs    = op_branch;
    assign id_uses_rt    = op_branch;
    assign rs_eq         = rs_fwd == rt_fwd;
    assign branch_taken  = op_branch && ((ins.i.opcode == OPC_BEQ) ? rs_eq : !rs_eq);
    assign branch_target = id_pc + 4 + {{(XLEN-18){ins.i.imm16[15]}}, ins.i.imm16, 2'b00};

    always_ff @(posedge aclk) begin
        if (!aresetn || ex_bubble) begin
            ex_regwen <= 1'b0;
            ex_load   <= 1'b0;
            ex_store  <= 1'b0;
        end else if (!stall) begin
            ex_regwen <= writes && wreg != '0;
            ex_load   <= op_load;
            ex_store  <= op_store;
        end
    end

    always_ff @(posedge aclk) begin
        if (!stall) begin
            ex_pc      <= id_pc;
            ex_a       <= rs_fwd;
            ex_b       <= rt_fwd;
            ex_imm     <= imm;
            ex_use_imm <= op_imm || op_load || op_store;
            ex_wreg    <= wreg;
            ex_rs      <= id_rs;
            ex_rt      <= id_rt;
            ex_shamt   <= ins.r.shamt;
            ex_alu_op  <= alu_op;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic [mips_pkg::XLEN-1:0]     ex_pc,
    input  logic [mips_pkg::XLEN-1:0]     ex_a,
    input  logic [mips_pkg::XLEN-1:0]     ex_b,
    input  logic [mips_pkg::XLEN-1:0]     ex_imm,
    input  logic                          ex_use_imm,
    input  logic                          ex_load,
    input  logic                          ex_store,
    input  logic                          ex_regwen,
    input  logic [mips_pkg::REG_AW-1:0]   ex_wreg,
    input  logic [mips_pkg::REG_AW-1:0]   ex_rs,
    input  logic [mips_pkg::REG_AW-1:0]   ex_rt,
    input  logic [mips_pkg::REG_AW-1:0]   ex_shamt,
    input  logic [mips_pkg::ALU_OP_W-1:0] ex_alu_op,
    input  logic [mips_pkg::XLEN-1:0]     data_rdata,
    output logic                          data_req,
    output logic                          data_wr,
    output logic [mips_pkg::XLEN-1:0]     data_addr,
    output logic [mips_pkg::XLEN-1:0]     data_wdata,
    output logic [3:0]                    data_wstrb,
    output logic                          wb_regwen,
    output logic [mips_pkg::REG_AW-1:0]   wb_wreg,
    output logic [mips_pkg::XLEN-1:0]     wb_data,
    output logic [mips_pkg::XLEN-1:0]     debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_wen,
    output logic [mips_pkg::REG_AW-1:0]   debug_wb_rf_wnum,
    output logic [mips_pkg::XLEN-1:0]     debug_wb_rf_wdata
);
    import mips_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_pc;
    logic [XLEN-1:0] wb_result;
    logic            wb_load;

    // previous instruction sits in writeback
    assign op_a  = (wb_regwen && wb_wreg == ex_rs) ? wb_data : ex_a;
    assign op_b  = (wb_regwen && wb_wreg == ex_rt) ? wb_data : ex_b;
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    alu u_alu (
        .a      (op_a),
        .b      (alu_b),
        .shamt  (ex_shamt),
        .op     (ex_alu_op),
        .result (alu_result)
    );

    // word access only
    assign data_req   = ex_load || ex_store;
    assign data_wr    = ex_store;
    assign data_addr  = alu_result;
    assign data_wdata = op_b;
    assign data_wstrb = {4{ex_store}};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wb_regwen <= 1'b0;
            wb_load   <= 1'b0;
        end else begin
            wb_regwen <= ex_regwen;
            wb_load   <= ex_load;
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc     <= ex_pc;
        wb_wreg   <= ex_wreg;
        wb_result <= alu_result;
    end

    // load data arrives in this cycle
    assign wb_data = wb_load ? data_rdata : wb_result;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_regwen}};
    assign debug_wb_rf_wnum  = wb_wreg;
    assign debug_wb_rf_wdata = wb_data;

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/1ns

module mips_core (
    input  logic                            aclk,
    input  logic                            aresetn,
    output logic                            inst_req,
    output logic [mips_pkg::XLEN-1:0]       inst_addr,
    input  logic [mips_pkg::XLEN-1:0]       inst_rdata,
    output logic                            data_req,
    output logic                            data_wr,
    output logic [mips_pkg::XLEN-1:0]       data_addr,
    output logic [3:0]                      data_wstrb,
    output logic [mips_pkg::XLEN-1:0]       data_wdata,
    input  logic [mips_pkg::XLEN-1:0]       data_rdata,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [mips_pkg::REG_AW-1:0]     debug_wb_rf_wnum,
    output logic [mips_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import mips_pkg::*;

    logic                stall;
    logic                ex_bubble;

    // fetch <-> decode
    logic [XLEN-1:0]     id_pc;
    logic                branch_taken;
    logic [XLEN-1:0]     branch_target;
    logic [REG_AW-1:0]   id_rs;
    logic [REG_AW-1:0]   id_rt;
    logic                id_uses_rs;
    logic                id_uses_rt;
    logic [XLEN-1:0]     rs_data;
    logic [XLEN-1:0]     rt_data;

    // decode -> execute
    logic [XLEN-1:0]     ex_pc;
    logic [XLEN-1:0]     ex_a;
    logic [XLEN-1:0]     ex_b;
    logic [XLEN-1:0]     ex_imm;
    logic                ex_use_imm;
    logic                ex_load;
    logic                ex_store;
    logic                ex_regwen;
    logic [REG_AW-1:0]   ex_wreg;
    logic [REG_AW-1:0]   ex_rs;
    logic [REG_AW-1:0]   ex_rt;
    logic [REG_AW-1:0]   ex_shamt;
    logic [ALU_OP_W-1:0] ex_alu_op;

    // writeback, also the forwarding source
    logic                wb_regwen;
    logic [REG_AW-1:0]   wb_wreg;
    logic [XLEN-1:0]     wb_data;

    pipe_control u_pipe_control (.*);

    fetch_unit u_fetch_unit (.*);

    decode_stage u_decode_stage (.*);

    reg_file u_reg_file (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rs      (id_rs),
        .rt      (id_rt),
        .wreg    (wb_wreg),
        .wen     (wb_regwen),
        .wdata   (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage u_execute_stage (.*);

endmodule

/* verification/tb_mips_core.sv */
`timescale 1ns/1ns

module tb_mips_core;
    import mips_pkg::*;

    // four programs under 100 instructions, at most 2 cycles each,
    // plus reset and drain per program, with wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    localparam logic [5:0] RAND_FN [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                                            FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] RAND_OPC [6] = '{OPC_ADDIU, OPC_ANDI, OPC_ORI, OPC_XORI,
                                            OPC_SLTI, OPC_LUI};

    logic              aclk;
    logic              aresetn;
    logic              inst_req;
    logic [XLEN-1:0]   inst_addr;
    logic [XLEN-1:0]   inst_rdata;
    logic              data_req;
    logic              data_wr;
    logic [XLEN-1:0]   data_addr;
    logic [3:0]        data_wstrb;
    logic [XLEN-1:0]   data_wdata;
    logic [XLEN-1:0]   data_rdata;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [3:0]        debug_wb_rf_wen;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] prog [$];

    // expected writebacks and stores from the model
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    logic        fetch_pend;
    logic [31:0] fetch_addr;
    logic        load_pend;
    logic [31:0] load_addr;
    logic        running;
    logic        first_fetch;
    int          reset_edges;
    int          cycle_count;
    int          error_count;
    int          check_count;
    integer      seed;

    mips_core u_mips_core (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd,
                                           input int rs, input int rt, input int shamt);
        instr_t w;
        w.r.opcode = OPC_SPECIAL;
        w.r.rs     = rs[4:0];
        w.r.rt     = rt[4:0];
        w.r.rd     = rd[4:0];
        w.r.shamt  = shamt[4:0];
        w.r.funct  = funct;
        return w;
    endfunction

    // argument order follows the assembler: rt, rs, immediate
    function automatic logic [31:0] i_word(input logic [5:0] opcode, input int rt,
                                           input int rs, input int imm);
        instr_t w;
        w.i.opcode = opcode;
        w.i.rs     = rs[4:0];
        w.i.rt     = rt[4:0];
        w.i.imm16  = imm[15:0];
        return w;
    endfunction

    function automatic logic [31:0] pattern_word(input int idx);
        return (idx * 32'h9e37_79b9) ^ 32'h00c8_8a5a;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED: %s expected %h actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    // in-order ISA model with one delay slot per branch
    task automatic build_expected();
        logic [31:0] regs [32];
        logic [31:0] mem [0:255];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        instr_t      w;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = 32'h0;
        for (int i = 0; i < 256; i++) mem[i] = dmem[i];
        exp_pc.delete();
        exp_reg.delete();
        exp_val.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        pc    = RESET_PC;
        npc   = RESET_PC + 32'd4;
        steps = 0;
        while (pc < 32'(prog.size() * 4) && steps < 512) begin
            w    = imem[pc[9:2]];
            a    = regs[w.r.rs];
            b    = regs[w.r.rt];
            sext = {{16{w.i.imm16[15]}}, w.i.imm16};
            zext = {16'h0, w.i.imm16};
            addr = a + sext;
            nnpc = npc + 32'd4;
            dst  = w.i.rt;
            wr   = 1'b1;
            res  = 32'h0;
            case (w.r.opcode)
                OPC_SPECIAL: begin
                    dst = w.r.rd;
                    case (w.r.funct)
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_NOR:  res = ~(a | b);
                        FN_SLT:  res = {31'h0, $signed(a) < $signed(b)};
                        FN_SLTU: res = {31'h0, a < b};
                        FN_SLL:  res = b << w.r.shamt;
                        FN_SRL:  res = b >> w.r.shamt;
                        FN_SRA:  res = $signed(b) >>> w.r.shamt;
                        default: wr = 1'b0;
                    endcase
                end
                OPC_ADDIU: res = a + sext;
                OPC_ANDI:  res = a & zext;
                OPC_ORI:   res = a | zext;
                OPC_XORI:  res = a ^ zext;
                OPC_SLTI:  res = {31'h0, $signed(a) < $signed(sext)};
                OPC_LUI:   res = {w.i.imm16, 16'h0};
                OPC_LW:    res = mem[addr[9:2]];
                OPC_SW: begin
                    wr = 1'b0;
                    mem[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                OPC_BEQ: begin
                    wr = 1'b0;
                    if (a == b) nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                OPC_BNE: begin
                    wr = 1'b0;
                    if (a != b) nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_pc.push_back(pc);
                exp_reg.push_back(dst);
                exp_val.push_back(res);
            end
            pc  = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic check_writeback();
        if (debug_wb_rf_wen != 4'h0) begin
            check_value("debug_wb_rf_wen", 32'hf, 32'(debug_wb_rf_wen));
            if (exp_pc.size() == 0) begin
                error_count++;
                $display("unexpected writeback from pc %h to register %0d", debug_wb_pc,
                         debug_wb_rf_wnum);
            end else begin
                check_value("debug_wb_pc", exp_pc.pop_front(), debug_wb_pc);
                check_value("debug_wb_rf_wnum", 32'(exp_reg.pop_front()),
                            32'(debug_wb_rf_wnum));
                check_value("debug_wb_rf_wdata", exp_val.pop_front(), debug_wb_rf_wdata);
            end
        end
    endtask

    task automatic check_store();
        if (data_req && data_wr) begin
            check_value("data_wstrb", 32'hf, 32'(data_wstrb));
            if (exp_st_addr.size() == 0) begin
                error_count++;
                $display("unexpected store to address %h", data_addr);
            end else begin
                check_value("data_addr", exp_st_addr.pop_front(), data_addr);
                check_value("data_wdata", exp_st_data.pop_front(), data_wdata);
            end
        end else if (data_req) begin
            check_value("data_wstrb", 32'h0, 32'(data_wstrb));
        end
    endtask

    // sample at the rising edge, answer on the next falling edge
    always @(posedge aclk) begin
        cycle_count++;
        fetch_pend = (inst_req === 1'b1);
        fetch_addr = inst_addr;
        load_pend  = (data_req === 1'b1) && !data_wr;
        load_addr  = data_addr;
        if (data_req === 1'b1 && data_wr) begin
            for (int n = 0; n < 4; n++) begin
                if (data_wstrb[n]) dmem[data_addr[9:2]][8*n +: 8] = data_wdata[8*n +: 8];
            end
        end
        if (!aresetn) begin
            if (reset_edges > 0) begin
                check_value("inst_req", 32'h0, 32'(inst_req));
                check_value("data_req", 32'h0, 32'(data_req));
                check_value("debug_wb_rf_wen", 32'h0, 32'(debug_wb_rf_wen));
            end
            reset_edges++;
            first_fetch = 1'b1;
        end else begin
            reset_edges = 0;
            if (first_fetch && inst_req === 1'b1) begin
                check_value("inst_addr", RESET_PC, inst_addr);
                first_fetch = 1'b0;
            end
            if (running) begin
                check_writeback();
                check_store();
            end
        end
    end

    always @(negedge aclk) begin
        inst_rdata = fetch_pend ? imem[fetch_addr[9:2]] : 32'h0;
        data_rdata = load_pend ? dmem[load_addr[9:2]] : 32'h0;
    end

    task automatic run_program();
        @(negedge aclk);
        running = 1'b0;
        aresetn = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
            dmem[i] = pattern_word(i);
        end
        build_expected();
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        running = 1'b1;
        while (exp_pc.size() != 0 || exp_st_addr.size() != 0) @(negedge aclk);
        // trailing nops, any late writeback is an error
        repeat (8) @(negedge aclk);
        running = 1'b0;
    endtask

    task automatic alu_chain_test();
        prog.delete();
        prog.push_back(i_word(OPC_LUI, 1, 0, 'h1234));
        prog.push_back(i_word(OPC_ORI, 1, 1, 'h5678));
        prog.push_back(i_word(OPC_ADDIU, 2, 1, -1));
        prog.push_back(r_word(FN_SUBU, 3, 2, 1, 0));
        prog.push_back(r_word(FN_XOR, 4, 3, 2, 0));
        prog.push_back(r_word(FN_NOR, 5, 4, 1, 0));
        prog.push_back(r_word(FN_AND, 6, 5, 4, 0));
        prog.push_back(r_word(FN_OR, 7, 6, 5, 0));
        prog.push_back(r_word(FN_SLL, 8, 0, 7, 4));
        prog.push_back(r_word(FN_SRL, 9, 0, 8, 3));
        prog.push_back(r_word(FN_SRA, 10, 0, 9, 7));
        prog.push_back(r_word(FN_SLT, 11, 10, 1, 0));
        prog.push_back(r_word(FN_SLTU, 12, 1, 10, 0));
        prog.push_back(i_word(OPC_SLTI, 13, 12, 5));
        prog.push_back(i_word(OPC_ANDI, 14, 10, 'hff0f));
        prog.push_back(i_word(OPC_XORI, 15, 14, 'haaaa));
        // $0 stays zero and never shows on the debug port
        prog.push_back(r_word(FN_ADDU, 0, 15, 15, 0));
        prog.push_back(r_word(FN_ADDU, 16, 0, 15, 0));
        run_program();
    endtask

    task automatic load_store_test();
        prog.delete();
        prog.push_back(i_word(OPC_ADDIU, 1, 0, 'h100));
        prog.push_back(i_word(OPC_LUI, 2, 0, 'hdead));
        prog.push_back(i_word(OPC_ORI, 2, 2, 'hbeef));
        prog.push_back(i_word(OPC_SW, 2, 1, 0));
        prog.push_back(i_word(OPC_ADDIU, 3, 2, 1));
        prog.push_back(i_word(OPC_SW, 3, 1, 4));
        prog.push_back(i_word(OPC_LW, 4, 1, 0));
        prog.push_back(r_word(FN_ADDU, 5, 4, 1, 0));
        prog.push_back(i_word(OPC_LW, 6, 1, 4));
        prog.push_back(i_word(OPC_SW, 6, 1, 8));
        prog.push_back(i_word(OPC_LW, 7, 1, 8));
        prog.push_back(i_word(OPC_LW, 8, 1, 12));
        prog.push_back(r_word(FN_XOR, 9, 8, 7, 0));
        prog.push_back(i_word(OPC_SW, 9, 1, -4));
        prog.push_back(i_word(OPC_LW, 10, 1, -4));
        run_program();
    endtask

    // offsets count words from the delay slot
    task automatic branch_test();
        prog.delete();
        prog.push_back(i_word(OPC_ADDIU, 1, 0, 5));
        prog.push_back(i_word(OPC_ADDIU, 2, 0, 5));
        prog.push_back(i_word(OPC_BEQ, 2, 1, 3));
        prog.push_back(i_word(OPC_ADDIU, 3, 0, 1));
        prog.push_back(i_word(OPC_ADDIU, 4, 0, 2));
        prog.push_back(i_word(OPC_ADDIU, 5, 0, 3));
        prog.push_back(i_word(OPC_BNE, 2, 1, 2));
        prog.push_back(i_word(OPC_ADDIU, 6, 0, 4));
        prog.push_back(i_word(OPC_ADDIU, 7, 1, 1));
        prog.push_back(i_word(OPC_BNE, 1, 7, 2));
        prog.push_back(i_word(OPC_ADDIU, 8, 0, 7));
        prog.push_back(i_word(OPC_ADDIU, 9, 0, 8));
        prog.push_back(i_word(OPC_BEQ, 1, 7, 2));
        prog.push_back(i_word(OPC_ORI, 10, 0, 9));
        prog.push_back(i_word(OPC_ADDIU, 11, 0, 10));
        // countdown loop, backward branch right after its operand
        prog.push_back(i_word(OPC_ADDIU, 12, 0, 3));
        prog.push_back(i_word(OPC_ADDIU, 12, 12, -1));
        prog.push_back(i_word(OPC_BNE, 0, 12, -2));
        prog.push_back(i_word(OPC_ADDIU, 13, 12, 'h10));
        prog.push_back(i_word(OPC_ADDIU, 14, 0, 'h55));
        run_program();
    endtask

    task automatic random_alu_test();
        int r;
        int sel;
        prog.delete();
        for (int k = 1; k < 8; k++) begin
            r = $random(seed);
            prog.push_back(i_word(OPC_LUI, k, 0, r >> 16));
            prog.push_back(i_word(OPC_ORI, k, k, r));
        end
        for (int n = 0; n < 64; n++) begin
            r   = $random(seed);
            sel = ($random(seed) & 32'h7fff_ffff) % 17;
            if (sel < 11) begin
                prog.push_back(r_word(RAND_FN[sel], r & 7, (r >> 3) & 7, (r >> 6) & 7,
                                      (r >> 9) & 31));
            end else begin
                prog.push_back(i_word(RAND_OPC[sel-11], r & 7, (r >> 3) & 7, r >> 16));
            end
        end
        run_program();
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        error_count++;
        $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        report_and_finish();
    end

    initial begin
        seed        = 32'hc88a;
        aresetn     = 1'b0;
        inst_rdata  = 32'h0;
        data_rdata  = 32'h0;
        fetch_pend  = 1'b0;
        fetch_addr  = 32'h0;
        load_pend   = 1'b0;
        load_addr   = 32'h0;
        running     = 1'b0;
        first_fetch = 1'b1;
        reset_edges = 0;
        cycle_count = 0;
        error_count = 0;
        check_count = 0;
        alu_chain_test();
        load_store_test();
        branch_test();
        random_alu_test();
        report_and_finish();
    end

endmodule

/* all.f */
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/pipe_control.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mips_core.sv
verification/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
